//--- flist.f
+incdir+.
cp0_pkg.sv
tlb_pkg.sv
cp0_decode.sv
tlb_array.sv
cp0_regs.sv
cp0_top.sv
tb_cp0.sv

//--- Makefile
TOP = tb_cp0

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module cp0_top

sim:
	verilator --binary -j 0 -f flist.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

//--- tb_cp0.sv
`include "cp0_macros.svh"

module tb_cp0;
	timeunit 1ns;
	timeprecision 100ps;

	logic             clk;
	logic             rst;
	logic             cmd_valid;
	cp0_pkg::cp0_op_e cmd_op;
	logic [7:0]       cmd_addr;
	logic [31:0]      cmd_wdata;
	logic [7:0]       exc_type;
	logic [31:0]      pc;
	logic             is_slot;
	logic [31:0]      bad_vaddr;
	logic [5:0]       int_num;
	logic [31:0]      rdata;
	logic             rdata_valid;
	logic [31:0]      epc;
	logic             int_happen;

	// reference model of the registers
	logic [7:0]  m_im = '0;
	logic        m_exl = 1'b0;
	logic        m_ie = 1'b0;
	logic        m_bd = 1'b0;
	logic        m_ti = 1'b0;
	logic [1:0]  m_ip_sw = '0;
	logic [4:0]  m_exccode = '0;
	logic [5:0]  m_int = '0;
	logic [31:0] m_epc;
	logic [31:0] m_badvaddr;
	logic        m_p = 1'b0;
	logic [3:0]  m_idx = '0;
	logic [18:0] m_vpn2;
	logic [7:0]  m_asid;
	logic [25:0] m_lo0;
	logic [25:0] m_lo1;
	// tlb entries, lo words carry g in bit 0
	logic        m_tv [16] = '{default: 1'b0};
	logic [18:0] m_tvpn [16];
	logic [7:0]  m_tasid [16];
	logic        m_tg [16];
	logic [25:0] m_tlo0 [16];
	logic [25:0] m_tlo1 [16];

	logic [31:0] exp_val [$];
	string       exp_name [$];
	logic [3:0]  written [$];
	logic [4:0]  t1_regs [$] = '{`CP0_STATUS_NUM, `CP0_CAUSE_NUM, `CP0_EPC_NUM,
		`CP0_ENTRYHI_NUM, `CP0_ENTRYLO0_NUM, `CP0_ENTRYLO1_NUM, `CP0_INDEX_NUM};
	logic [15:0] lfsr = 16'd43;
	int          n_checks = 0;
	int          n_errors = 0;
	int          err_mark = 0;

	cp0_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [7:0] model_ip();
		return {m_int[5] | m_ti, m_int[4:0], m_ip_sw};
	endfunction

	// expected MFC0 data from the model
	function automatic logic [31:0] expected_read(input logic [4:0] regn);
		case (regn)
			`CP0_INDEX_NUM:    return {m_p, 27'd0, m_idx};
			`CP0_ENTRYLO0_NUM: return {6'd0, m_lo0};
			`CP0_ENTRYLO1_NUM: return {6'd0, m_lo1};
			`CP0_BADVADDR_NUM: return m_badvaddr;
			`CP0_ENTRYHI_NUM:  return {m_vpn2, 5'd0, m_asid};
			`CP0_STATUS_NUM:   return {9'd0, 1'b1, 6'd0, m_im, 6'd0, m_exl, m_ie};
			`CP0_CAUSE_NUM:    return {m_bd, m_ti, 14'd0, model_ip(), 1'b0, m_exccode, 2'd0};
			`CP0_EPC_NUM:      return m_epc;
			default:           return 32'd0;
		endcase
	endfunction

	function automatic logic expected_int();
		return !m_exl && m_ie && (|(m_im & model_ip()));
	endfunction

	// interrupt, fetch adel, ri, sys, bp, ov, data adel, ades
	function automatic logic [4:0] exc_code_of(input logic [7:0] et);
		if (et[cp0_pkg::EB_INT])
			return `EXC_INT;
		if (et[cp0_pkg::EB_FETCH_ADEL])
			return `EXC_ADEL;
		if (et[cp0_pkg::EB_RI])
			return `EXC_RI;
		if (et[cp0_pkg::EB_SYS])
			return `EXC_SYS;
		if (et[cp0_pkg::EB_BP])
			return `EXC_BP;
		if (et[cp0_pkg::EB_OV])
			return `EXC_OV;
		if (et[cp0_pkg::EB_DATA_ADEL])
			return `EXC_ADEL;
		return `EXC_ADES;
	endfunction

	function automatic logic [31:0] key_word();
		return {17'd0, 2'(rand_bits(2)), 5'(rand_bits(5)), 7'd0, 1'(rand_bits(1))};
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("ERROR t=%0t %s got %08h expected %08h", $time, name, got, exp);
		end
	endtask

	task automatic write_model(input logic [4:0] regn, input logic [31:0] wd);
		case (regn)
			`CP0_STATUS_NUM: begin
				m_im = wd[15:8];
				m_exl = wd[1];
				m_ie = wd[0];
			end
			`CP0_CAUSE_NUM:    m_ip_sw = wd[9:8];
			`CP0_EPC_NUM:      m_epc = wd;
			`CP0_COMPARE_NUM:  m_ti = 1'b0;
			`CP0_INDEX_NUM:    m_idx = wd[3:0];
			`CP0_ENTRYLO0_NUM: m_lo0 = wd[25:0];
			`CP0_ENTRYLO1_NUM: m_lo1 = wd[25:0];
			`CP0_ENTRYHI_NUM: begin
				m_vpn2 = wd[31:13];
				m_asid = wd[7:0];
			end
			default: ;
		endcase
	endtask

	task automatic tlb_model(input cp0_pkg::cp0_op_e op);
		logic       g;
		logic       hit;
		logic [3:0] e;
		g = m_lo0[0] & m_lo1[0];
		hit = 1'b0;
		if (op == cp0_pkg::OP_TLBWI) begin
			m_tv[m_idx] = 1'b1;
			m_tvpn[m_idx] = m_vpn2;
			m_tasid[m_idx] = m_asid;
			m_tg[m_idx] = g;
			m_tlo0[m_idx] = {m_lo0[25:1], g};
			m_tlo1[m_idx] = {m_lo1[25:1], g};
		end else if (op == cp0_pkg::OP_TLBR) begin
			m_vpn2 = m_tvpn[m_idx];
			m_asid = m_tasid[m_idx];
			m_lo0 = m_tlo0[m_idx];
			m_lo1 = m_tlo1[m_idx];
		end else begin
			m_p = 1'b1;
			m_idx = 4'd0;
			for (int i = 0; i < 16; i++) begin
				e = 4'(i);
				if (!hit && m_tv[e] && m_tvpn[e] == m_vpn2
					&& (m_tg[e] || m_tasid[e] == m_asid)) begin
					hit = 1'b1;
					m_p = 1'b0;
					m_idx = e;
				end
			end
		end
	endtask

	task automatic issue(input cp0_pkg::cp0_op_e op, input logic [4:0] regn,
		input logic [31:0] wd);
		@(posedge clk);
		#2;
		cmd_valid = 1'b1;
		cmd_op = op;
		cmd_addr = {regn, 3'd0};
		cmd_wdata = wd;
		exc_type = 8'd0;
		if (op == cp0_pkg::OP_MTC0)
			write_model(regn, wd);
		else if (op == cp0_pkg::OP_MFC0) begin
			exp_val.push_back(expected_read(regn));
			exp_name.push_back($sformatf("rdata reg%0d", regn));
		end else if (op == cp0_pkg::OP_ERET)
			m_exl = 1'b0;
		else if (op != cp0_pkg::OP_NOP && op != cp0_pkg::OP_EXC)
			tlb_model(op);
	endtask

	task automatic raise(input logic [7:0] et, input logic [31:0] pcv, input logic slot,
		input logic [31:0] bva);
		@(posedge clk);
		#2;
		cmd_valid = 1'b1;
		cmd_op = cp0_pkg::OP_EXC;
		exc_type = et;
		pc = pcv;
		is_slot = slot;
		bad_vaddr = bva;
		if (!m_exl) begin
			m_bd = slot;
			m_epc = slot ? pcv - 32'd4 : pcv;
		end
		m_exl = 1'b1;
		m_exccode = exc_code_of(et);
		if (et[cp0_pkg::EB_FETCH_ADEL] | et[cp0_pkg::EB_DATA_ADEL] | et[cp0_pkg::EB_ADES])
			m_badvaddr = bva;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
			cmd_valid = 1'b0;
			exc_type = 8'd0;
		end
	endtask

	task automatic set_int_num(input logic [5:0] v);
		idle(1);
		int_num = v;
		m_int = v;
	endtask

	task automatic finish_test(input string name);
		int n;
		n = 0;
		idle(1);
		while (exp_val.size() != 0 && n < 20) begin
			idle(1);
			n++;
		end
		if (exp_val.size() != 0) begin
			n_errors++;
			$display("read data for %0d MFC0 commands never arrived", exp_val.size());
			exp_val.delete();
			exp_name.delete();
		end
		$display("test %s: %0d errors", name, n_errors - err_mark);
		err_mark = n_errors;
	endtask

	// compare read data at the falling edge
	always @(negedge clk) begin
		if (!rst && rdata_valid) begin
			if (exp_val.size() == 0) begin
				n_errors++;
				$display("read data arrived at %0t with no MFC0 outstanding", $time);
			end else
				check(exp_name.pop_front(), rdata, exp_val.pop_front());
		end
	end

	initial begin
		int n;
		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd_op = cp0_pkg::OP_NOP;
		cmd_addr = 8'd0;
		cmd_wdata = 32'd0;
		exc_type = 8'd0;
		pc = 32'd0;
		is_slot = 1'b0;
		bad_vaddr = 32'd0;
		int_num = 6'd0;
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;

		for (int r = 0; r < 7; r++) begin
			repeat (2) begin
				issue(cp0_pkg::OP_MTC0, t1_regs[r], rand_bits(32));
				issue(cp0_pkg::OP_MFC0, t1_regs[r], 32'd0);
			end
		end
		finish_test("1 register write and read");

		for (int k = 0; k < 3; k++) begin
			issue(cp0_pkg::OP_MTC0, `CP0_STATUS_NUM, rand_bits(32) & ~32'h2);
			raise(8'h08, rand_bits(32), 1'(rand_bits(1)), 32'd0);
			raise(8'h04, rand_bits(32), 1'(rand_bits(1)), 32'd0);
			issue(cp0_pkg::OP_MFC0, `CP0_EPC_NUM, 32'd0);
			issue(cp0_pkg::OP_MFC0, `CP0_CAUSE_NUM, 32'd0);
			check("epc", epc, m_epc);
			issue(cp0_pkg::OP_MFC0, `CP0_STATUS_NUM, 32'd0);
			issue(cp0_pkg::OP_ERET, 5'd0, 32'd0);
			issue(cp0_pkg::OP_MFC0, `CP0_STATUS_NUM, 32'd0);
		end
		finish_test("2 nested exception and eret");

		for (int k = 0; k < 6; k++) begin
			issue(cp0_pkg::OP_ERET, 5'd0, 32'd0);
			raise(8'(rand_bits(8)) | (8'h10 << (rand_bits(2) % 3)), rand_bits(32),
				1'(rand_bits(1)), rand_bits(32));
			issue(cp0_pkg::OP_MFC0, `CP0_BADVADDR_NUM, 32'd0);
			issue(cp0_pkg::OP_MFC0, `CP0_CAUSE_NUM, 32'd0);
		end
		issue(cp0_pkg::OP_ERET, 5'd0, 32'd0);
		finish_test("3 address error and priority");

		for (int k = 0; k < 8; k++) begin
			set_int_num(6'(rand_bits(6)));
			issue(cp0_pkg::OP_MTC0, `CP0_STATUS_NUM, rand_bits(32) & ~32'h2);
			issue(cp0_pkg::OP_MTC0, `CP0_CAUSE_NUM, rand_bits(32));
			issue(cp0_pkg::OP_MFC0, `CP0_CAUSE_NUM, 32'd0);
			idle(2);
			check("int_happen", {31'd0, int_happen}, {31'd0, expected_int()});
		end
		finish_test("4 interrupt request");

		set_int_num(6'd0);
		issue(cp0_pkg::OP_MTC0, `CP0_CAUSE_NUM, 32'd0);
		issue(cp0_pkg::OP_MTC0, `CP0_STATUS_NUM, 32'h0000_8001);
		issue(cp0_pkg::OP_MTC0, `CP0_COMPARE_NUM, 32'd8);
		issue(cp0_pkg::OP_MTC0, `CP0_COUNT_NUM, 32'd0);
		n = 0;
		idle(1);
		while (!int_happen && n < 100) begin
			idle(1);
			n++;
		end
		if (!int_happen) begin
			n_errors++;
			$display("timer interrupt did not arrive within 100 cycles");
		end
		m_ti = 1'b1;
		issue(cp0_pkg::OP_MFC0, `CP0_CAUSE_NUM, 32'd0);
		issue(cp0_pkg::OP_MTC0, `CP0_COMPARE_NUM, 32'hffff_ffff);
		// ip7 follows ti one cycle later
		idle(1);
		issue(cp0_pkg::OP_MFC0, `CP0_CAUSE_NUM, 32'd0);
		idle(1);
		check("int_happen", {31'd0, int_happen}, {31'd0, expected_int()});
		finish_test("5 timer");

		for (int k = 0; k < 8; k++) begin
			written.push_back(4'(rand_bits(4)));
			issue(cp0_pkg::OP_MTC0, `CP0_INDEX_NUM, {28'd0, written[k]});
			issue(cp0_pkg::OP_MTC0, `CP0_ENTRYHI_NUM, key_word());
			issue(cp0_pkg::OP_MTC0, `CP0_ENTRYLO0_NUM, rand_bits(32));
			issue(cp0_pkg::OP_MTC0, `CP0_ENTRYLO1_NUM, rand_bits(32));
			issue(cp0_pkg::OP_TLBWI, 5'd0, 32'd0);
		end
		for (int k = 0; k < 8; k++) begin
			issue(cp0_pkg::OP_MTC0, `CP0_INDEX_NUM, {28'd0, written[k]});
			issue(cp0_pkg::OP_TLBR, 5'd0, 32'd0);
			issue(cp0_pkg::OP_MFC0, `CP0_ENTRYHI_NUM, 32'd0);
			issue(cp0_pkg::OP_MFC0, `CP0_ENTRYLO0_NUM, 32'd0);
			issue(cp0_pkg::OP_MFC0, `CP0_ENTRYLO1_NUM, 32'd0);
		end
		for (int k = 0; k < 9; k++) begin
			// last key has a vpn2 that no entry holds
			issue(cp0_pkg::OP_MTC0, `CP0_ENTRYHI_NUM, (k == 8) ? 32'hffff_e000 : key_word());
			issue(cp0_pkg::OP_TLBP, 5'd0, 32'd0);
			issue(cp0_pkg::OP_MFC0, `CP0_INDEX_NUM, 32'd0);
		end
		finish_test("6 tlb write, read and probe");

		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- cp0_top.sv
module cp0_top (
	input  logic             clk,
	input  logic             rst,
	input  logic             cmd_valid,
	input  cp0_pkg::cp0_op_e cmd_op,
	input  logic [7:0]       cmd_addr,
	input  logic [31:0]      cmd_wdata,
	input  logic [7:0]       exc_type,
	input  logic [31:0]      pc,
	input  logic             is_slot,
	input  logic [31:0]      bad_vaddr,
	input  logic [5:0]       int_num,
	output logic [31:0]      rdata,
	output logic             rdata_valid,
	output logic [31:0]      epc,
	output logic             int_happen
);

	logic             s2_valid;
	cp0_pkg::cp0_op_e s2_op;
	logic [31:0]      s2_reg_sel;
	logic [31:0]      s2_wdata;
	logic [4:0]       s2_exccode;
	logic             s2_any_exc;
	logic             s2_addr_exc;
	logic [31:0]      s2_pc;
	logic             s2_is_slot;
	logic [31:0]      s2_bad_vaddr;

	logic [31:0]                   entryhi;
	logic [tlb_pkg::TLB_IDX_W-1:0] tlb_idx;
	logic                          tlb_we;
	tlb_pkg::tlb_entry_t           tlb_wentry;
	tlb_pkg::tlb_entry_t           tlb_rentry;
	logic                          probe_hit;
	logic [tlb_pkg::TLB_IDX_W-1:0] probe_idx;

	cp0_decode u_decode (
		.clk, .rst, .cmd_valid, .cmd_op, .cmd_addr, .cmd_wdata, .exc_type, .pc, .is_slot,
		.bad_vaddr, .s2_valid, .s2_op, .s2_reg_sel, .s2_wdata, .s2_exccode, .s2_any_exc,
		.s2_addr_exc, .s2_pc, .s2_is_slot, .s2_bad_vaddr
	);

	cp0_regs u_regs (
		.clk, .rst, .int_num, .s2_valid, .s2_op, .s2_reg_sel, .s2_wdata, .s2_exccode,
		.s2_any_exc, .s2_addr_exc, .s2_pc, .s2_is_slot, .s2_bad_vaddr, .tlb_rentry,
		.probe_hit, .probe_idx, .rdata, .rdata_valid, .epc, .int_happen, .entryhi,
		.tlb_idx, .tlb_we, .tlb_wentry
	);

	tlb_array u_tlb (
		.clk, .rst, .entryhi, .tlb_idx, .tlb_we, .tlb_wentry, .tlb_rentry, .probe_hit,
		.probe_idx
	);

endmodule

//--- cp0_regs.sv
`include "cp0_macros.svh"

module cp0_regs (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [5:0]                    int_num,
	input  logic                          s2_valid,
	input  cp0_pkg::cp0_op_e              s2_op,
	input  logic [31:0]                   s2_reg_sel,
	input  logic [31:0]                   s2_wdata,
	input  logic [4:0]                    s2_exccode,
	input  logic                          s2_any_exc,
	input  logic                          s2_addr_exc,
	input  logic [31:0]                   s2_pc,
	input  logic                          s2_is_slot,
	input  logic [31:0]                   s2_bad_vaddr,
	input  tlb_pkg::tlb_entry_t           tlb_rentry,
	input  logic                          probe_hit,
	input  logic [tlb_pkg::TLB_IDX_W-1:0] probe_idx,
	output logic [31:0]                   rdata,
	output logic                          rdata_valid,
	output logic [31:0]                   epc,
	output logic                          int_happen,
	output logic [31:0]                   entryhi,
	output logic [tlb_pkg::TLB_IDX_W-1:0] tlb_idx,
	output logic                          tlb_we,
	output tlb_pkg::tlb_entry_t           tlb_wentry
);

	cp0_pkg::cp0_word_u wr_word;
	cp0_pkg::cp0_word_u status_rd;
	cp0_pkg::cp0_word_u cause_rd;
	logic        mtc0, mfc0, eret, tlbp, tlbr;
	logic        wr_status, wr_cause, wr_epc, wr_count, wr_compare;
	logic        wr_index, wr_entryhi, wr_entrylo0, wr_entrylo1;
	logic [7:0]  status_im;
	logic        status_exl;
	logic        status_ie;
	logic        cause_bd;
	logic        cause_ti;
	logic [7:0]  cause_ip;
	logic [4:0]  cause_exccode;
	logic [31:0] badvaddr;
	logic [32:0] count;
	logic [31:0] compare;
	logic        index_p;
	logic [tlb_pkg::TLB_IDX_W-1:0] index_idx;
	logic [31:0] index_word;
	logic [18:0] ehi_vpn2;
	logic [7:0]  ehi_asid;
	logic [25:0] entrylo0;
	logic [25:0] entrylo1;
	logic [31:0] rd_mux;

	assign mtc0 = s2_valid && (s2_op == cp0_pkg::OP_MTC0);
	assign mfc0 = s2_valid && (s2_op == cp0_pkg::OP_MFC0);
	assign eret = s2_valid && (s2_op == cp0_pkg::OP_ERET);
	assign tlbp = s2_valid && (s2_op == cp0_pkg::OP_TLBP);
	assign tlbr = s2_valid && (s2_op == cp0_pkg::OP_TLBR);
	assign tlb_we = s2_valid && (s2_op == cp0_pkg::OP_TLBWI);

	assign wr_status   = mtc0 && s2_reg_sel[`CP0_STATUS_NUM];
	assign wr_cause    = mtc0 && s2_reg_sel[`CP0_CAUSE_NUM];
	assign wr_epc      = mtc0 && s2_reg_sel[`CP0_EPC_NUM];
	assign wr_count    = mtc0 && s2_reg_sel[`CP0_COUNT_NUM];
	assign wr_compare  = mtc0 && s2_reg_sel[`CP0_COMPARE_NUM];
	assign wr_index    = mtc0 && s2_reg_sel[`CP0_INDEX_NUM];
	assign wr_entryhi  = mtc0 && s2_reg_sel[`CP0_ENTRYHI_NUM];
	assign wr_entrylo0 = mtc0 && s2_reg_sel[`CP0_ENTRYLO0_NUM];
	assign wr_entrylo1 = mtc0 && s2_reg_sel[`CP0_ENTRYLO1_NUM];

	assign wr_word = s2_wdata;

	// status
	always_ff @(posedge clk) begin
		if (rst) begin
			status_im  <= 8'd0;
			status_exl <= 1'b0;
			status_ie  <= 1'b0;
		end else begin
			if (wr_status) begin
				status_im <= wr_word.status.im;
				status_ie <= wr_word.status.ie;
			end
			if (s2_any_exc)
				status_exl <= 1'b1;
			else if (eret)
				status_exl <= 1'b0;
			else if (wr_status)
				status_exl <= wr_word.status.exl;
		end
	end

	// cause; ip7 folds in the timer
	always_ff @(posedge clk) begin
		if (rst) begin
			cause_bd      <= 1'b0;
			cause_ti      <= 1'b0;
			cause_ip      <= 8'd0;
			cause_exccode <= 5'd0;
		end else begin
			if (s2_any_exc && !status_exl)
				cause_bd <= s2_is_slot;
			if (wr_compare)
				cause_ti <= 1'b0;
			else if (count[32:1] == compare)
				cause_ti <= 1'b1;
			cause_ip[7:2] <= {int_num[5] | cause_ti, int_num[4:0]};
			if (wr_cause)
				cause_ip[1:0] <= wr_word.cause.ip[1:0];
			if (s2_any_exc)
				cause_exccode <= s2_exccode;
		end
	end

	// epc keeps the first faulting pc while exl is set
	always_ff @(posedge clk) begin
		if (s2_any_exc && !status_exl)
			epc <= s2_is_slot ? s2_pc - 32'd4 : s2_pc;
		else if (wr_epc)
			epc <= s2_wdata;
	end

	always_ff @(posedge clk) begin
		if (s2_addr_exc)
			badvaddr <= s2_bad_vaddr;
	end

	// count runs at half the clock rate
	always_ff @(posedge clk) begin
		if (rst) begin
			count   <= 33'd0;
			compare <= 32'hffff_ffff;
		end else begin
			if (wr_count)
				count <= {s2_wdata, 1'b0};
			else
				count <= count + 33'd1;
			if (wr_compare)
				compare <= s2_wdata;
		end
	end

	// index, p flags a probe miss
	always_ff @(posedge clk) begin
		if (rst) begin
			index_p   <= 1'b0;
			index_idx <= '0;
		end else if (tlbp) begin
			index_p   <= !probe_hit;
			index_idx <= probe_idx;
		end else if (wr_index) begin
			index_idx <= s2_wdata[tlb_pkg::TLB_IDX_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (tlbr) begin
			ehi_vpn2 <= tlb_rentry.vpn2;
			ehi_asid <= tlb_rentry.asid;
			entrylo0 <= {tlb_rentry.pfn0, tlb_rentry.c0, tlb_rentry.d0, tlb_rentry.v0,
				tlb_rentry.g};
			entrylo1 <= {tlb_rentry.pfn1, tlb_rentry.c1, tlb_rentry.d1, tlb_rentry.v1,
				tlb_rentry.g};
		end else begin
			if (wr_entryhi) begin
				ehi_vpn2 <= s2_wdata[31:13];
				ehi_asid <= s2_wdata[7:0];
			end
			if (wr_entrylo0)
				entrylo0 <= s2_wdata[25:0];
			if (wr_entrylo1)
				entrylo1 <= s2_wdata[25:0];
		end
	end

	assign entryhi = {ehi_vpn2, 5'd0, ehi_asid};
	assign tlb_idx = index_idx;
	assign index_word = {index_p, {(31 - tlb_pkg::TLB_IDX_W){1'b0}}, index_idx};

	always_comb begin
		tlb_wentry.vpn2 = ehi_vpn2;
		tlb_wentry.asid = ehi_asid;
		tlb_wentry.g    = entrylo0[0] & entrylo1[0];
		tlb_wentry.pfn0 = entrylo0[25:6];
		tlb_wentry.c0   = entrylo0[5:3];
		tlb_wentry.d0   = entrylo0[2];
		tlb_wentry.v0   = entrylo0[1];
		tlb_wentry.pfn1 = entrylo1[25:6];
		tlb_wentry.c1   = entrylo1[5:3];
		tlb_wentry.d1   = entrylo1[2];
		tlb_wentry.v1   = entrylo1[1];
	end

	always_comb begin
		status_rd = '0;
		status_rd.status.bev = 1'b1;
		status_rd.status.im  = status_im;
		status_rd.status.exl = status_exl;
		status_rd.status.ie  = status_ie;
		cause_rd = '0;
		cause_rd.cause.bd      = cause_bd;
		cause_rd.cause.ti      = cause_ti;
		cause_rd.cause.ip      = cause_ip;
		cause_rd.cause.exccode = cause_exccode;
	end

	assign rd_mux = ({32{s2_reg_sel[`CP0_INDEX_NUM]}} & index_word)
		| ({32{s2_reg_sel[`CP0_ENTRYLO0_NUM]}} & {6'd0, entrylo0})
		| ({32{s2_reg_sel[`CP0_ENTRYLO1_NUM]}} & {6'd0, entrylo1})
		| ({32{s2_reg_sel[`CP0_BADVADDR_NUM]}} & badvaddr)
		| ({32{s2_reg_sel[`CP0_COUNT_NUM]}} & count[32:1])
		| ({32{s2_reg_sel[`CP0_ENTRYHI_NUM]}} & entryhi)
		| ({32{s2_reg_sel[`CP0_COMPARE_NUM]}} & compare)
		| ({32{s2_reg_sel[`CP0_STATUS_NUM]}} & status_rd)
		| ({32{s2_reg_sel[`CP0_CAUSE_NUM]}} & cause_rd)
		| ({32{s2_reg_sel[`CP0_EPC_NUM]}} & epc);

	always_ff @(posedge clk) begin
		if (rst)
			rdata_valid <= 1'b0;
		else
			rdata_valid <= mfc0;
	end

	always_ff @(posedge clk) begin
		if (mfc0)
			rdata <= rd_mux;
	end

	assign int_happen = !status_exl && status_ie && (|(status_im & cause_ip));

endmodule

//--- tlb_array.sv
`include "cp0_macros.svh"

module tlb_array (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [31:0]                   entryhi,
	input  logic [tlb_pkg::TLB_IDX_W-1:0] tlb_idx,
	input  logic                          tlb_we,
	input  tlb_pkg::tlb_entry_t           tlb_wentry,
	output tlb_pkg::tlb_entry_t           tlb_rentry,
	output logic                          probe_hit,
	output logic [tlb_pkg::TLB_IDX_W-1:0] probe_idx
);

	tlb_pkg::tlb_entry_t entries [`CP0_TLBNUM];
	logic [`CP0_TLBNUM-1:0] entry_vld;
	logic [`CP0_TLBNUM-1:0] match;
	logic [18:0] key_vpn2;
	logic [7:0]  key_asid;

	assign key_vpn2 = entryhi[31:13];
	assign key_asid = entryhi[7:0];

	// entries not written since reset stay out of a probe
	always_ff @(posedge clk) begin
		if (rst)
			entry_vld <= '0;
		else if (tlb_we)
			entry_vld[tlb_idx] <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (tlb_we)
			entries[tlb_idx] <= tlb_wentry;
	end

	assign tlb_rentry = entries[tlb_idx];

	always_comb begin
		for (int i = 0; i < `CP0_TLBNUM; i++) begin
			match[i] = entry_vld[i] && (entries[i].vpn2 == key_vpn2)
				&& (entries[i].g || (entries[i].asid == key_asid));
		end
	end

	// scan downwards so the lowest match wins
	always_comb begin
		probe_idx = '0;
		for (int i = `CP0_TLBNUM - 1; i >= 0; i--) begin
			if (match[i])
				probe_idx = i[tlb_pkg::TLB_IDX_W-1:0];
		end
	end

	assign probe_hit = |match;

endmodule

//--- cp0_decode.sv
`include "cp0_macros.svh"

module cp0_decode (
	input  logic              clk,
	input  logic              rst,
	input  logic              cmd_valid,
	input  cp0_pkg::cp0_op_e  cmd_op,
	input  logic [7:0]        cmd_addr,
	input  logic [31:0]       cmd_wdata,
	input  logic [7:0]        exc_type,
	input  logic [31:0]       pc,
	input  logic              is_slot,
	input  logic [31:0]       bad_vaddr,
	output logic              s2_valid,
	output cp0_pkg::cp0_op_e  s2_op,
	output logic [31:0]       s2_reg_sel,
	output logic [31:0]       s2_wdata,
	output logic [4:0]        s2_exccode,
	output logic              s2_any_exc,
	output logic              s2_addr_exc,
	output logic [31:0]       s2_pc,
	output logic              s2_is_slot,
	output logic [31:0]       s2_bad_vaddr
);

	logic [31:0] reg_sel;
	logic [4:0]  exccode;
	logic        is_exc;
	logic        addr_err;

	// only select 0 addresses a register
	assign reg_sel = (cmd_addr[2:0] == 3'd0) ? (32'd1 << cmd_addr[7:3]) : 32'd0;

	assign is_exc = cmd_valid && (cmd_op == cp0_pkg::OP_EXC) && (|exc_type);
	assign addr_err = exc_type[cp0_pkg::EB_FETCH_ADEL] | exc_type[cp0_pkg::EB_DATA_ADEL]
		| exc_type[cp0_pkg::EB_ADES];

	// fixed priority, interrupt first
	always_comb begin
		if (exc_type[cp0_pkg::EB_INT])
			exccode = `EXC_INT;
		else if (exc_type[cp0_pkg::EB_FETCH_ADEL])
			exccode = `EXC_ADEL;
		else if (exc_type[cp0_pkg::EB_RI])
			exccode = `EXC_RI;
		else if (exc_type[cp0_pkg::EB_SYS])
			exccode = `EXC_SYS;
		else if (exc_type[cp0_pkg::EB_BP])
			exccode = `EXC_BP;
		else if (exc_type[cp0_pkg::EB_OV])
			exccode = `EXC_OV;
		else if (exc_type[cp0_pkg::EB_DATA_ADEL])
			exccode = `EXC_ADEL;
		else
			exccode = `EXC_ADES;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			s2_valid    <= 1'b0;
			s2_any_exc  <= 1'b0;
			s2_addr_exc <= 1'b0;
		end else begin
			s2_valid    <= cmd_valid;
			s2_any_exc  <= is_exc;
			s2_addr_exc <= is_exc && addr_err;
		end
	end

	always_ff @(posedge clk) begin
		s2_op        <= cmd_op;
		s2_reg_sel   <= reg_sel;
		s2_wdata     <= cmd_wdata;
		s2_exccode   <= exccode;
		s2_pc        <= pc;
		s2_is_slot   <= is_slot;
		s2_bad_vaddr <= bad_vaddr;
	end

endmodule

//--- tlb_pkg.sv
`include "cp0_macros.svh"

package tlb_pkg;

	localparam int TLB_IDX_W = $clog2(`CP0_TLBNUM);

	typedef logic [TLB_IDX_W-1:0] tlb_idx_t;

	// 78 bits: vpn2, asid, g, then even page, then odd page
	typedef struct packed {
		logic [18:0] vpn2;
		logic [7:0]  asid;
		logic        g;
		logic [19:0] pfn0;
		logic [2:0]  c0;
		logic        d0;
		logic        v0;
		logic [19:0] pfn1;
		logic [2:0]  c1;
		logic        d1;
		logic        v1;
	} tlb_entry_t;

endpackage

//--- cp0_pkg.sv
package cp0_pkg;

	typedef enum logic [2:0] {
		OP_NOP   = 3'd0,
		OP_MTC0  = 3'd1,
		OP_MFC0  = 3'd2,
		OP_EXC   = 3'd3,
		OP_ERET  = 3'd4,
		OP_TLBP  = 3'd5,
		OP_TLBR  = 3'd6,
		OP_TLBWI = 3'd7
	} cp0_op_e;

	// bit positions in exc_type
	typedef enum logic [2:0] {
		EB_OV         = 3'd0,
		EB_RI         = 3'd1,
		EB_BP         = 3'd2,
		EB_SYS        = 3'd3,
		EB_ADES       = 3'd4,
		EB_DATA_ADEL  = 3'd5,
		EB_FETCH_ADEL = 3'd6,
		EB_INT        = 3'd7
	} exc_bit_e;

	typedef struct packed {
		logic [8:0] rsvd_hi;
		logic       bev;
		logic [5:0] rsvd_mid;
		logic [7:0] im;
		logic [5:0] rsvd_lo;
		logic       exl;
		logic       ie;
	} status_t;

	typedef struct packed {
		logic        bd;
		logic        ti;
		logic [13:0] rsvd_hi;
		logic [7:0]  ip;
		logic        rsvd_mid;
		logic [4:0]  exccode;
		logic [1:0]  rsvd_lo;
	} cause_t;

	// same 32 bits seen as Status or Cause
	typedef union packed {
		status_t status;
		cause_t  cause;
	} cp0_word_u;

endpackage

//--- cp0_macros.svh
`ifndef CP0_MACROS_SVH
`define CP0_MACROS_SVH

// tlb size
`define CP0_TLBNUM 16

// register numbers, select 0
`define CP0_INDEX_NUM    0
`define CP0_ENTRYLO0_NUM 2
`define CP0_ENTRYLO1_NUM 3
`define CP0_BADVADDR_NUM 8
`define CP0_COUNT_NUM    9
`define CP0_ENTRYHI_NUM  10
`define CP0_COMPARE_NUM  11
`define CP0_STATUS_NUM   12
`define CP0_CAUSE_NUM    13
`define CP0_EPC_NUM      14

// cause.exccode values
`define EXC_INT  5'h00
`define EXC_ADEL 5'h04
`define EXC_ADES 5'h05
`define EXC_SYS  5'h08
`define EXC_BP   5'h09
`define EXC_RI   5'h0a
`define EXC_OV   5'h0c

`endif
